// ==== logic/v2t_cfg.svh ====
//////////////////////////////////////////////////
// v2t channel configuration
// sizes, comparator threshold and count limit
// shared by the packages and the RTL stages
//////////////////////////////////////////////////

`ifndef V2T_CFG_SVH
`define V2T_CFG_SVH

`define V2T_VIN_W    10    // input sample width
`define V2T_NCTL     3     // log2 of unit current cells

`define V2T_VLTH     64    // comparator threshold, sample units

`define V2T_CODE_W   10    // output code width
`define V2T_CNT_MAX  1023  // ramp count saturation

`endif

// ==== logic/v2t_data_pkg.sv ====
//////////////////////////////////////////////////
// v2t data types
// sample and code words carried through the
// channel, sized from the shared configuration
//////////////////////////////////////////////////

`default_nettype none

`include "v2t_cfg.svh"

package v2t_data_pkg;

    //////////////////////////////////////////////////
    // sample side

    typedef logic [`V2T_VIN_W-1:0] vin_t;  // unsigned input sample, also held level

    //////////////////////////////////////////////////
    // readout side

    typedef logic [`V2T_CODE_W-1:0] code_t;  // ramp length in cycles

endpackage : v2t_data_pkg

`default_nettype wire

// ==== logic/v2t_ramp_pkg.sv ====
//////////////////////////////////////////////////
// v2t ramp types
// thermometer current control, unit cell count
// and the ramp FSM state encoding
//////////////////////////////////////////////////

`default_nettype none

`include "v2t_cfg.svh"

package v2t_ramp_pkg;

    typedef logic [2**`V2T_NCTL-1:0] ramp_ctl_t;  // thermometer control, one bit per cell
    typedef logic [`V2T_NCTL:0]      iramp_t;     // enabled cells, 0 .. 2**NCTL

    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // waiting for a held sample
        PRECHARGE = 2'd1,  // load level, pulse goes low
        RAMP      = 2'd2,  // discharge by iramp per cycle
        DONE      = 2'd3   // wait for the counter to drain
    } ramp_state_e;

    // count of enabled unit cells, order of the bits does not matter
    function automatic iramp_t cells_on(input ramp_ctl_t ctl);
        iramp_t n;
        n = '0;
        for (int i = 0; i < $bits(ramp_ctl_t); i++) begin
            n = n + iramp_t'(ctl[i]);  // add one cell
        end
        return n;
    endfunction

endpackage : v2t_ramp_pkg

`default_nettype wire

// ==== logic/v2t_sample_hold.sv ====
//////////////////////////////////////////////////
// v2t sample-and-hold
// takes a sample and its ramp control on the
// input req/ack handshake, holds them in one
// register and offers them to the ramp stage
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module v2t_sample_hold
    import v2t_data_pkg::*, v2t_ramp_pkg::*;
(
    input  wire logic      clk_v2t_lb,
    input  wire logic      arst_n,
    input  wire logic      in_req,    // sample offered
    input  wire vin_t      vin,
    input  wire ramp_ctl_t ctl,
    output logic           in_ack,
    output logic           hold_req,  // held sample offered downstream
    output vin_t           hold_vin,
    output ramp_ctl_t      hold_ctl,
    input  wire logic      hold_ack
);

    logic full;  // register holds a sample not yet taken
    logic take;  // capture this cycle

    // empty, and the previous transfer to the ramp has fully closed
    assign take = in_req && !in_ack && !full && !hold_ack;

    always_ff @(posedge clk_v2t_lb or negedge arst_n) begin
        if (!arst_n) begin
            in_ack   <= 1'b0;
            hold_req <= 1'b0;
            full     <= 1'b0;
        end else begin
            // input side
            if (take) begin
                in_ack <= 1'b1;  // answer one cycle after req
                full   <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;  // close phase four
            end
            // ramp side
            if (hold_req && hold_ack) begin
                hold_req <= 1'b0;  // ramp has it
                full     <= 1'b0;  // free for the next sample
            end else if (full && !hold_req && !hold_ack) begin
                hold_req <= 1'b1;
            end
        end
    end

    // holding register, stable until the ramp acks
    always_ff @(posedge clk_v2t_lb) begin
        if (take) begin
            hold_vin <= vin;
            hold_ctl <= ctl;
        end
    end

endmodule : v2t_sample_hold

`default_nettype wire

// ==== logic/v2t_ramp_pulse.sv ====
//////////////////////////////////////////////////
// v2t ramp and pulse generator
// precharges, then discharges the held level by
// the ramp current each cycle until it crosses
// the threshold; v2t_out is low over the ramp
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "v2t_cfg.svh"

module v2t_ramp_pulse
    import v2t_data_pkg::*, v2t_ramp_pkg::*;
(
    input  wire logic      clk_v2t_lb,
    input  wire logic      arst_n,
    input  wire logic      hold_req,
    input  wire vin_t      hold_vin,
    input  wire ramp_ctl_t hold_ctl,
    output logic           hold_ack,
    output logic           ramp_active,  // window seen by the counter
    input  wire logic      ramp_stop,    // count limit reached
    input  wire logic      busy,         // counter still holds a result
    output logic           v2t_out
);

    ramp_state_e state;
    vin_t        level;     // remaining level above threshold
    iramp_t      iramp;     // unit cells discharging
    vin_t        lvl_init;  // level loaded in precharge
    logic        start;
    logic        ramp_end;

    assign start = (state == IDLE) && hold_req && !hold_ack;

    // clip at zero, at or below threshold gives no ramp
    assign lvl_init = (hold_vin > vin_t'(`V2T_VLTH)) ? hold_vin - vin_t'(`V2T_VLTH) : '0;

    // crossing happens in this cycle
    assign ramp_end = (level <= vin_t'(iramp)) || ramp_stop;

    // precharge plus ramp cycles, the same span as v2t_out low
    assign ramp_active = (state == PRECHARGE) || (state == RAMP);

    //////////////////////////////////////////////////
    // control FSM

    always_ff @(posedge clk_v2t_lb or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            hold_ack <= 1'b0;
            v2t_out  <= 1'b0;
        end else begin
            if (hold_ack && !hold_req) begin
                hold_ack <= 1'b0;  // phase four toward sample-hold
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= PRECHARGE;
                        hold_ack <= 1'b1;
                        v2t_out  <= 1'b0;  // falls as precharge begins
                    end else begin
                        v2t_out  <= 1'b1;  // idle high
                    end
                end
                PRECHARGE: begin
                    if (lvl_init == '0) begin
                        state   <= DONE;  // skip the ramp
                        v2t_out <= 1'b1;
                    end else begin
                        state   <= RAMP;
                    end
                end
                RAMP: begin
                    if (ramp_end) begin
                        state   <= DONE;
                        v2t_out <= 1'b1;  // comparator trips
                    end
                end
                DONE: begin
                    if (!busy) begin
                        state <= IDLE;  // counter took the result
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // level datapath

    always_ff @(posedge clk_v2t_lb) begin
        if (state == PRECHARGE) begin
            level <= lvl_init;
            iramp <= cells_on(hold_ctl);  // thermometer to cell count
        end else if (state == RAMP) begin
            level <= ramp_end ? '0 : level - vin_t'(iramp);
        end
    end

endmodule : v2t_ramp_pulse

`default_nettype wire

// ==== logic/v2t_tdc_counter.sv ====
//////////////////////////////////////////////////
// v2t time-to-digital counter
// counts ramp cycles with saturation, then
// returns the code on the output handshake
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "v2t_cfg.svh"

module v2t_tdc_counter
    import v2t_data_pkg::*;
(
    input  wire logic clk_v2t_lb,
    input  wire logic arst_n,
    input  wire logic ramp_active,
    output logic      ramp_stop,  // end the ramp, limit reached
    output logic      busy,       // result not yet drained
    output logic      out_req,
    output code_t     code,
    output logic      overflow,
    input  wire logic out_ack
);

    logic ramp_d;    // ramp_active one cycle late
    logic ack_wait;  // out_req dropped, waiting for ack low
    logic step;      // a ramp cycle to count
    logic fall;

    // first cycle of the window is precharge, not counted
    assign step      = ramp_active && ramp_d;
    assign ramp_stop = step && (code == code_t'(`V2T_CNT_MAX - 1));
    assign fall      = ramp_d && !ramp_active;
    assign busy      = ramp_d || out_req || ack_wait;

    always_ff @(posedge clk_v2t_lb or negedge arst_n) begin
        if (!arst_n) begin
            ramp_d   <= 1'b0;
            ack_wait <= 1'b0;
            out_req  <= 1'b0;
            code     <= '0;
            overflow <= 1'b0;
        end else begin
            ramp_d <= ramp_active;
            if (step && (code != code_t'(`V2T_CNT_MAX))) begin
                code <= code + 1'b1;  // saturating count
            end
            if (ramp_stop) begin
                overflow <= 1'b1;
            end
            // output handshake, code frozen while it runs
            if (fall) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req  <= 1'b0;
                ack_wait <= 1'b1;
            end else if (ack_wait && !out_ack) begin
                ack_wait <= 1'b0;  // transfer closed
                code     <= '0;
                overflow <= 1'b0;
            end
        end
    end

endmodule : v2t_tdc_counter

`default_nettype wire

// ==== logic/v2t_channel.sv ====
//////////////////////////////////////////////////
// v2t channel top
// sample-hold, ramp pulse and TDC counter in a
// chain, all joined by four-phase req/ack
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module v2t_channel
    import v2t_data_pkg::*, v2t_ramp_pkg::*;
(
    input  wire logic      clk_v2t_lb,
    input  wire logic      arst_n,
    input  wire logic      in_req,
    input  wire vin_t      vin,       // input sample
    input  wire ramp_ctl_t ctl,       // ramp current, thermometer
    output wire logic      in_ack,
    output wire logic      out_req,
    output wire code_t     code,      // ramp length in cycles
    output wire logic      overflow,  // count saturated
    input  wire logic      out_ack,
    output wire logic      v2t_out    // low while the ramp runs
);

    wire logic      hold_req;
    wire logic      hold_ack;
    wire vin_t      hold_vin;
    wire ramp_ctl_t hold_ctl;
    wire logic      ramp_active;
    wire logic      ramp_stop;
    wire logic      busy;

    v2t_sample_hold u_sample_hold (
        .clk_v2t_lb (clk_v2t_lb),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .vin        (vin),
        .ctl        (ctl),
        .in_ack     (in_ack),
        .hold_req   (hold_req),
        .hold_vin   (hold_vin),
        .hold_ctl   (hold_ctl),
        .hold_ack   (hold_ack)
    );

    v2t_ramp_pulse u_ramp_pulse (
        .clk_v2t_lb  (clk_v2t_lb),
        .arst_n      (arst_n),
        .hold_req    (hold_req),
        .hold_vin    (hold_vin),
        .hold_ctl    (hold_ctl),
        .hold_ack    (hold_ack),
        .ramp_active (ramp_active),
        .ramp_stop   (ramp_stop),
        .busy        (busy),
        .v2t_out     (v2t_out)
    );

    v2t_tdc_counter u_tdc_counter (
        .clk_v2t_lb  (clk_v2t_lb),
        .arst_n      (arst_n),
        .ramp_active (ramp_active),
        .ramp_stop   (ramp_stop),
        .busy        (busy),
        .out_req     (out_req),
        .code        (code),
        .overflow    (overflow),
        .out_ack     (out_ack)
    );

endmodule : v2t_channel

`default_nettype wire

// ==== verification/v2t_channel_tb.sv ====
//////////////////////////////////////////////////
// v2t channel testbench
// random samples through the channel, codes and
// pulse widths against a reference model
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "v2t_cfg.svh"

module v2t_channel_tb
    import v2t_data_pkg::*, v2t_ramp_pkg::*;
();

    localparam int N_SAMPLES    = 213;                             // all tests together
    localparam int WATCHDOG_CYC = N_SAMPLES * (`V2T_CNT_MAX + 10);

    logic      clk_v2t_lb;
    logic      arst_n;
    logic      in_req;
    vin_t      vin;
    ramp_ctl_t ctl;
    logic      in_ack;
    logic      out_req;
    code_t     code;
    logic      overflow;
    logic      out_ack;
    logic      v2t_out;

    logic [31:0]          rng = 32'he90546cf;  // LCG state
    logic [`V2T_CODE_W:0] exp_q[$];            // {overflow, code} per sample in send order
    int                   pulse_q[$];          // measured v2t_out low widths
    int                   ack_delay_q[$];      // out_ack delays for the back-pressure test
    int err_cnt      = 0;
    int hs_err       = 0;  // handshake order violations
    int n_sent       = 0;
    int n_checked    = 0;
    int n_in_taken   = 0;
    int n_out_acked  = 0;
    int low_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int t0;
    int ack_wait;
    logic ack_pending = 1'b0;
    logic req_seen;
    logic mon_en      = 1'b0;
    logic in_req_d    = 1'b0;
    logic in_ack_d    = 1'b0;
    logic out_req_d   = 1'b0;
    logic out_ack_d   = 1'b0;

    v2t_channel DUT (.*);

    initial begin
        clk_v2t_lb = 1'b0;
        forever #5 clk_v2t_lb = ~clk_v2t_lb;  // 10 ns
    end

    //////////////////////////////////////////////////
    // reference model and helpers

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic ramp_ctl_t therm(input int n);
        ramp_ctl_t c;
        int        j;
        c = '0;
        for (j = 0; j < n; j++)
            c[j] = 1'b1;  // fill from the bottom
        return c;
    endfunction

    // expected {overflow, code} for one sample
    function automatic logic [`V2T_CODE_W:0] ref_result(input vin_t v, input ramp_ctl_t c);
        int d;
        int n;
        int q;
        d = int'(v) - `V2T_VLTH;
        n = $countones(c);
        if (d <= 0)
            return '0;  // no ramp at all
        q = (n == 0) ? `V2T_CNT_MAX : (d + n - 1) / n;  // no current never crosses
        if (q >= `V2T_CNT_MAX)
            return {1'b1, code_t'(`V2T_CNT_MAX)};
        return {1'b0, code_t'(q)};
    endfunction

    task automatic flag_mismatch(input string sig, input int got, input int expv);
        $display("[FAIL] %0d ns: %s = %0d, expected %0d", $time, sig, got, expv);
        err_cnt++;
    endtask

    task automatic flag_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic order_fail(input string msg);
        $display("error at %0d ns: handshake order, %s", $time, msg);
        hs_err++;
    endtask

    task automatic send_sample(input vin_t v, input ramp_ctl_t c);
        @(posedge clk_v2t_lb);
        in_req <= 1'b1;
        vin    <= v;
        ctl    <= c;
        exp_q.push_back(ref_result(v, c));
        n_sent++;
        do @(negedge clk_v2t_lb); while (!in_ack);
        @(posedge clk_v2t_lb);
        in_req <= 1'b0;  // phase three
        do @(negedge clk_v2t_lb); while (in_ack);
    endtask

    task automatic send_random();
        logic [31:0] r;
        r = next_rand();
        send_sample(vin_t'(r[25:16]), therm(int'(r[31:28]) % 9));  // 0..8 cells
    endtask

    task automatic wait_results();
        while (n_checked < n_sent || n_out_acked < n_sent || out_ack)
            @(posedge clk_v2t_lb);
    endtask

    task automatic end_test(input string name, input int start_errs);
        tests_run++;
        if (err_cnt == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, err_cnt - start_errs);
        end
    endtask

    task automatic compare_result();
        logic [`V2T_CODE_W:0] e;
        int                   w;
        if (exp_q.size() == 0) begin
            flag_error("out_req raised with no sample outstanding");
            return;
        end
        e = exp_q.pop_front();
        n_checked++;
        if (code !== e[`V2T_CODE_W-1:0])
            flag_mismatch("code", code, e[`V2T_CODE_W-1:0]);
        if (overflow !== e[`V2T_CODE_W])
            flag_mismatch("overflow", overflow, e[`V2T_CODE_W]);
        if (pulse_q.size() == 0) begin
            flag_error("no v2t_out pulse came before this result");
        end else begin
            w = pulse_q.pop_front();
            if (w != int'(e[`V2T_CODE_W-1:0]) + 1)
                flag_mismatch("v2t_out low cycles", w, int'(e[`V2T_CODE_W-1:0]) + 1);
        end
    endtask

    //////////////////////////////////////////////////
    // monitor, pulse widths, handshake order, compare

    always @(negedge clk_v2t_lb) begin
        if (!mon_en) begin
            low_cnt = 0;
        end else begin
            if (!v2t_out) begin
                low_cnt++;  // ramp still running
            end else if (low_cnt > 0) begin
                pulse_q.push_back(low_cnt);
                low_cnt = 0;
            end
            if (in_ack && !in_ack_d && !in_req_d)
                order_fail("in_ack rose without in_req");
            if (!in_ack && in_ack_d && in_req)
                order_fail("in_ack fell while in_req high");
            if (!out_req && out_req_d && !out_ack_d)
                order_fail("out_req fell before out_ack");
            if (out_ack && !out_ack_d)
                n_out_acked++;
            if (in_ack && !in_ack_d) begin
                if (n_in_taken > n_out_acked + 1)  // at most two in flight
                    flag_error("sample accepted before the older result was acknowledged");
                n_in_taken++;
            end
            if (out_req && !out_req_d)
                compare_result();
        end
        in_req_d  = in_req;
        in_ack_d  = in_ack;
        out_req_d = out_req;
        out_ack_d = out_ack;
    end

    // out_ack driver with a drawn delay
    initial begin
        out_ack = 1'b0;
        forever begin
            @(negedge clk_v2t_lb);
            req_seen = out_req;
            @(posedge clk_v2t_lb);
            if (out_ack) begin
                if (!req_seen)
                    out_ack <= 1'b0;  // phase four
            end else if (req_seen) begin
                if (!ack_pending) begin
                    ack_pending = 1'b1;
                    ack_wait    = (ack_delay_q.size() > 0) ? ack_delay_q.pop_front() : 0;
                end
                if (ack_wait == 0) begin
                    out_ack     <= 1'b1;
                    ack_pending = 1'b0;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("timeout: %0d of %0d results checked after %0d cycles",
                 n_checked, n_sent, WATCHDOG_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        arst_n = 1'b0;
        in_req = 1'b0;
        vin    = '0;
        ctl    = '0;
        repeat (3) @(posedge clk_v2t_lb);
        arst_n <= 1'b1;
        t0 = err_cnt;
        @(negedge clk_v2t_lb);
        if (in_ack !== 1'b0)
            flag_mismatch("in_ack", in_ack, 0);
        if (out_req !== 1'b0)
            flag_mismatch("out_req", out_req, 0);
        if (overflow !== 1'b0)
            flag_mismatch("overflow", overflow, 0);
        if (v2t_out !== 1'b0)
            flag_mismatch("v2t_out", v2t_out, 0);
        end_test("reset state", t0);
        repeat (2) @(posedge clk_v2t_lb);
        mon_en = 1'b1;  // v2t_out idles high by now

        t0 = err_cnt;
        send_sample(vin_t'(0), therm(3));
        send_sample(vin_t'(1), therm(8));
        send_sample(vin_t'(`V2T_VLTH - 1), therm(0));
        send_sample(vin_t'(`V2T_VLTH), therm(5));
        wait_results();
        end_test("below threshold", t0);

        t0 = err_cnt;
        repeat (200) send_random();
        wait_results();
        end_test("random coverage", t0);

        t0 = err_cnt;
        send_sample('1, therm(0));  // no current so the count runs out
        send_sample(vin_t'(`V2T_VLTH + 1), therm(0));
        send_sample('1, therm(1));  // longest real ramp
        wait_results();
        end_test("saturation", t0);

        t0 = err_cnt;
        repeat (6) ack_delay_q.push_back(int'(next_rand() % 21));
        repeat (6) send_random();
        wait_results();
        end_test("back-pressure", t0);

        t0 = err_cnt;
        err_cnt += hs_err;
        if (out_req || out_ack || in_ack)
            flag_error("a handshake was left open at the end");
        end_test("handshake order", t0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule : v2t_channel_tb

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/v2t_data_pkg.sv
logic/v2t_ramp_pkg.sv
logic/v2t_sample_hold.sv
logic/v2t_ramp_pulse.sv
logic/v2t_tdc_counter.sv
logic/v2t_channel.sv
verification/v2t_channel_tb.sv

// ==== Makefile ====
# Verilator build and run of the v2t channel testbench
TOP := v2t_channel_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search the log for the pass line"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || { echo "simulation failed"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
